/* axi_rd_config.svh */
// AXI read subordinate configuration
`ifndef AXI_RD_CONFIG_SVH
`define AXI_RD_CONFIG_SVH

// --------------------
// Bus widths
// --------------------
// Byte address width on AR and toward the component
`define AXI_RD_AW 32
// Read data width, same for AXI and component
`define AXI_RD_DW 32
// Transaction ID width
`define AXI_RD_IW 4

// --------------------
// Component timing
// --------------------
// Cycles from an accepted request (dv && !hld) to valid rdata/err
`define AXI_RD_C_LAT 2

`endif

/* axi_rd_pkg.sv */
// AXI read subordinate types
package axi_rd_pkg;

`include "axi_rd_config.svh"

    // AxBURST encoding, RESERVED behaves as FIXED
    typedef enum logic [1:0] {
        AXI_BURST_FIXED    = 2'b00,
        AXI_BURST_INCR     = 2'b01,
        AXI_BURST_WRAP     = 2'b10,
        AXI_BURST_RESERVED = 2'b11
    } axi_burst_e;

    // xRESP encoding
    // Only OKAY and SLVERR come out of this design
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    // Per-beat context that travels alongside a component request
    typedef struct packed {
        logic [`AXI_RD_IW-1:0] id;
        axi_resp_e             resp;
        logic                  last;
    } rd_beat_t;

    // Full response beat held in the skid stages
    typedef struct packed {
        logic [`AXI_RD_DW-1:0] data;
        rd_beat_t              beat;
    } rd_resp_t;

endpackage

/* rd_resp_if.sv */
// Response beat link
`timescale 1ns/1ps
`include "axi_rd_config.svh"

interface rd_resp_if import axi_rd_pkg::*; ();

    // Beat from the context pipeline, no stall possible
    logic                  valid;
    logic [`AXI_RD_DW-1:0] data;
    logic [`AXI_RD_IW-1:0] id;
    axi_resp_e             resp;
    logic                  last;

    // High when every skid stage can take one more beat
    logic                  space;

    // Context pipeline side
    modport src (output valid, data, id, resp, last, input space);

    // Data pipeline side
    modport dst (input valid, data, id, resp, last, output space);

endinterface

/* burst_addr_calc.sv */
// AXI burst next address
`timescale 1ns/1ps
`include "axi_rd_config.svh"

module burst_addr_calc import axi_rd_pkg::*; (
    input  logic [`AXI_RD_AW-1:0] i_addr,
    input  logic [2:0]            i_size,
    input  axi_burst_e            i_burst,
    input  logic [7:0]            i_len,
    output logic [`AXI_RD_AW-1:0] o_next_addr
);

    localparam int AW = `AXI_RD_AW;

    logic [AW-1:0] beat_bytes;
    logic [AW-1:0] addr_algn;
    logic [AW-1:0] addr_incr;
    logic [8:0]    wrap_beats;
    logic [AW-1:0] wrap_mask;

    // --------------------
    // Common terms
    // --------------------
    always_comb begin
        // Bytes per beat, 1 << AxSIZE
        beat_bytes = AW'(1) << i_size;
        // Unaligned start address snaps down to the beat size
        addr_algn  = i_addr & ~(beat_bytes - AW'(1));
        addr_incr  = addr_algn + beat_bytes;
        // Wrap region is (len+1) beats, len+1 is a power of two for WRAP
        wrap_beats = {1'b0, i_len} + 9'd1;
        wrap_mask  = (AW'(wrap_beats) << i_size) - AW'(1);
    end

    // --------------------
    // Burst select
    // --------------------
    always_comb begin
        case (i_burst)
            AXI_BURST_INCR: begin
                o_next_addr = addr_incr;
            end
            AXI_BURST_WRAP: begin
                // Upper bits fixed to the region, lower bits roll over
                o_next_addr = (i_addr & ~wrap_mask) | (addr_incr & wrap_mask);
            end
            // FIXED and RESERVED repeat the address
            default: begin
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

/* ar_txn_ctrl.sv */
// AR acceptance and beat issue
`timescale 1ns/1ps
`include "axi_rd_config.svh"

module ar_txn_ctrl import axi_rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // AR channel
    input  logic                  i_arvalid,
    output logic                  o_arready,
    input  logic [`AXI_RD_AW-1:0] i_araddr,
    input  logic [1:0]            i_arburst,
    input  logic [2:0]            i_arsize,
    input  logic [7:0]            i_arlen,
    input  logic [`AXI_RD_IW-1:0] i_arid,
    // Pipeline space and component hold
    input  logic                  i_space,
    input  logic                  i_hld,
    // Component request
    output logic                  o_dv,
    output logic [`AXI_RD_AW-1:0] o_addr,
    output logic [`AXI_RD_IW-1:0] o_id,
    output logic [2:0]            o_size,
    output logic                  o_last,
    // Toward the context pipeline
    output logic                  o_issue,
    output rd_beat_t              o_beat
);

    localparam int AW = `AXI_RD_AW;
    localparam int AG = $clog2(`AXI_RD_DW / 8);

    logic                  out_of_rst;
    logic                  active;
    logic                  ar_hs;
    logic                  final_beat;
    logic [AW-1:0]         ctx_addr;
    axi_burst_e            ctx_burst;
    logic [2:0]            ctx_size;
    logic [7:0]            ctx_len;
    logic [`AXI_RD_IW-1:0] ctx_id;
    logic [7:0]            beat_cnt;
    logic [AW-1:0]         addr_nxt;

    // --------------------
    // AR handshake
    // --------------------
    // Hold off one cycle after reset, then accept when idle or
    // when the last beat of the current burst goes out
    assign o_arready = out_of_rst && (!active || final_beat);
    assign ar_hs     = i_arvalid && o_arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_rst <= 1'b0;
        end else begin
            out_of_rst <= 1'b1;
        end
    end

    // Active until the final request is issued
    // Data for it may still be in flight afterwards
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (ar_hs) begin
            active <= 1'b1;
        end else if (final_beat) begin
            active <= 1'b0;
        end
    end

    // Burst context, new AR wins over the issue update
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            ctx_addr  <= i_araddr;
            ctx_burst <= axi_burst_e'(i_arburst);
            ctx_size  <= i_arsize;
            ctx_len   <= i_arlen;
            ctx_id    <= i_arid;
        end else if (o_issue) begin
            ctx_addr  <= addr_nxt;
        end
    end

    // Remaining beats, holds at zero once the burst is done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (ar_hs) begin
            beat_cnt <= i_arlen;
        end else if (o_issue && (beat_cnt != 8'd0)) begin
            beat_cnt <= beat_cnt - 8'd1;
        end
    end

    // --------------------
    // Component request
    // --------------------
    // Only request when the skid chain can absorb the result
    assign o_dv       = active && i_space;
    assign o_issue    = o_dv && !i_hld;
    assign final_beat = o_issue && o_last;

    // Address forced to data-width alignment
    assign o_addr = ctx_addr & ~AW'((1 << AG) - 1);
    assign o_id   = ctx_id;
    assign o_size = ctx_size;
    assign o_last = (beat_cnt == 8'd0);

    assign o_beat = '{id: ctx_id, resp: AXI_RESP_OKAY, last: o_last};

    // Full unaligned address feeds the next-address logic for narrow beats
    burst_addr_calc i_burst_addr_calc (
        .i_addr      (ctx_addr),
        .i_size      (ctx_size),
        .i_burst     (ctx_burst),
        .i_len       (ctx_len),
        .o_next_addr (addr_nxt)
    );

endmodule

/* rd_ctx_pipe.sv */
// Request context latency pipeline
`timescale 1ns/1ps
`include "axi_rd_config.svh"

module rd_ctx_pipe import axi_rd_pkg::*; #(
    parameter int C_LAT = `AXI_RD_C_LAT
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Issued request and its context
    input  logic                  i_issue,
    input  rd_beat_t              i_beat,
    // Component return, C_LAT cycles after issue
    input  logic [`AXI_RD_DW-1:0] i_rdata,
    input  logic                  i_err,
    // Joined beat toward the data pipeline
    rd_resp_if.src                resp
);

    // Stage 0 is the issue cycle, stage C_LAT lines up with rdata
    logic     valid_sr [C_LAT+1];
    rd_beat_t beat_sr  [C_LAT+1];

    assign valid_sr[0] = i_issue;
    assign beat_sr[0]  = i_beat;

    // --------------------
    // Shift register
    // --------------------
    for (genvar gi = 1; gi <= C_LAT; gi++) begin : g_stage
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_sr[gi] <= 1'b0;
            end else begin
                valid_sr[gi] <= valid_sr[gi-1];
            end
        end

        // Context follows valid, no reset on the payload
        always_ff @(posedge clk) begin
            beat_sr[gi] <= beat_sr[gi-1];
        end
    end

    // --------------------
    // Join with component data
    // --------------------
    assign resp.valid = valid_sr[C_LAT];
    assign resp.data  = i_rdata;
    assign resp.id    = beat_sr[C_LAT].id;
    // Component error overrides the carried response
    assign resp.resp  = i_err ? AXI_RESP_SLVERR : beat_sr[C_LAT].resp;
    assign resp.last  = beat_sr[C_LAT].last;

endmodule

/* skid_buffer.sv */
// Valid/ready skid stage
`timescale 1ns/1ps

module skid_buffer import axi_rd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // Upstream
    input  logic     i_valid,
    output logic     o_ready,
    input  rd_resp_t i_data,
    // Downstream
    output logic     o_valid,
    input  logic     i_ready,
    output rd_resp_t o_data
);

    logic     skid_valid;
    rd_resp_t skid_data;

    // --------------------
    // Handshake
    // --------------------
    // Ready depends only on the skid register, no combinational path back
    assign o_ready = !skid_valid;

    // Held beat goes first, otherwise pass through
    assign o_valid = skid_valid || i_valid;
    assign o_data  = skid_valid ? skid_data : i_data;

    // --------------------
    // Skid register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // Drains once downstream takes it
            if (i_ready) begin
                skid_valid <= 1'b0;
            end
        end else if (i_valid && !i_ready) begin
            // Accepted from upstream but downstream stalled
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_valid && i_valid && !i_ready) begin
            skid_data <= i_data;
        end
    end

endmodule

/* rd_data_pipe.sv */
// Read data skid chain
`timescale 1ns/1ps
`include "axi_rd_config.svh"

module rd_data_pipe import axi_rd_pkg::*; #(
    parameter int C_LAT = `AXI_RD_C_LAT
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Beats from the context pipeline
    rd_resp_if.dst                resp,
    // R channel
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output logic [`AXI_RD_DW-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    output logic [`AXI_RD_IW-1:0] o_rid,
    output logic                  o_rlast
);

    // Index 0 is the chain input, index C_LAT+1 is the R channel
    logic     [C_LAT+1:0] stg_valid;
    logic     [C_LAT+1:0] stg_ready;
    rd_resp_t [C_LAT+1:0] stg_data;

    assign stg_valid[0] = resp.valid;
    assign stg_data[0]  = '{data: resp.data,
                            beat: '{id: resp.id, resp: resp.resp, last: resp.last}};

    // One stage per beat that can be in flight, plus one
    for (genvar gi = 0; gi <= C_LAT; gi++) begin : g_skid
        skid_buffer i_skid_buffer (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (stg_valid[gi]),
            .o_ready (stg_ready[gi]),
            .i_data  (stg_data[gi]),
            .o_valid (stg_valid[gi+1]),
            .i_ready (stg_ready[gi+1]),
            .o_data  (stg_data[gi+1])
        );
    end

    // Space only when no stage holds a beat, rready not included
    assign resp.space = &stg_ready[C_LAT:0];

    // --------------------
    // R channel
    // --------------------
    assign stg_ready[C_LAT+1] = i_rready;
    assign o_rvalid = stg_valid[C_LAT+1];
    assign o_rdata  = stg_data[C_LAT+1].data;
    assign o_rresp  = stg_data[C_LAT+1].beat.resp;
    assign o_rid    = stg_data[C_LAT+1].beat.id;
    assign o_rlast  = stg_data[C_LAT+1].beat.last;

endmodule

/* axi_rd_sub.sv */
// AXI read subordinate
`timescale 1ns/1ps
`include "axi_rd_config.svh"

module axi_rd_sub import axi_rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // AR channel
    input  logic                  i_arvalid,
    output logic                  o_arready,
    input  logic [`AXI_RD_AW-1:0] i_araddr,
    input  logic [1:0]            i_arburst,
    input  logic [2:0]            i_arsize,
    input  logic [7:0]            i_arlen,
    input  logic [`AXI_RD_IW-1:0] i_arid,
    // R channel
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output logic [`AXI_RD_DW-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    output logic [`AXI_RD_IW-1:0] o_rid,
    output logic                  o_rlast,
    // Component
    output logic                  o_dv,
    output logic [`AXI_RD_AW-1:0] o_addr,
    output logic [`AXI_RD_IW-1:0] o_id,
    output logic [2:0]            o_size,
    output logic                  o_last,
    input  logic                  i_hld,
    input  logic                  i_err,
    input  logic [`AXI_RD_DW-1:0] i_rdata
);

    // Issue strobe and beat context into the latency pipeline
    logic     issue;
    rd_beat_t issue_beat;

    // Beat link between the context and data pipelines
    rd_resp_if i_rd_resp ();

    ar_txn_ctrl i_ar_txn_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .i_arburst (i_arburst),
        .i_arsize  (i_arsize),
        .i_arlen   (i_arlen),
        .i_arid    (i_arid),
        .i_space   (i_rd_resp.space),
        .i_hld     (i_hld),
        .o_dv      (o_dv),
        .o_addr    (o_addr),
        .o_id      (o_id),
        .o_size    (o_size),
        .o_last    (o_last),
        .o_issue   (issue),
        .o_beat    (issue_beat)
    );

    rd_ctx_pipe #(
        .C_LAT (`AXI_RD_C_LAT)
    ) i_rd_ctx_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_issue (issue),
        .i_beat  (issue_beat),
        .i_rdata (i_rdata),
        .i_err   (i_err),
        .resp    (i_rd_resp.src)
    );

    rd_data_pipe #(
        .C_LAT (`AXI_RD_C_LAT)
    ) i_rd_data_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .resp     (i_rd_resp.dst),
        .o_rvalid (o_rvalid),
        .i_rready (i_rready),
        .o_rdata  (o_rdata),
        .o_rresp  (o_rresp),
        .o_rid    (o_rid),
        .o_rlast  (o_rlast)
    );

endmodule

/* tb_axi_rd_sub.sv */
// AXI read subordinate testbench
`timescale 1ns/1ps
`include "axi_rd_config.svh"

module tb_axi_rd_sub import axi_rd_pkg::*; ();

    localparam int AW      = `AXI_RD_AW;
    localparam int DW      = `AXI_RD_DW;
    localparam int IW      = `AXI_RD_IW;
    localparam int C_LAT   = `AXI_RD_C_LAT;
    localparam int N_RAND  = 24;
    localparam int N_BURST = 8 + N_RAND;
    // 20 cycles of 8 ns per burst plus slack
    localparam int WDOG_NS = N_BURST * 20 * 8 + 2000;
    localparam logic [DW-1:0] DATA_KEY = 32'h5a3c_96e1;
    // Component flags err inside this word range
    localparam logic [AW-1:0] ERR_LO = 32'h0000_5000;
    localparam logic [AW-1:0] ERR_HI = 32'h0000_5010;

    typedef struct packed {
        logic [AW-1:0] addr;
        logic [IW-1:0] id;
        logic [2:0]    size;
        logic          last;
    } req_t;

    typedef struct packed {
        logic [DW-1:0] data;
        logic [1:0]    resp;
        logic [IW-1:0] id;
        logic          last;
    } beat_t;

    typedef struct packed {
        logic [AW-1:0] addr;
        logic [1:0]    burst;
        logic [2:0]    size;
        logic [7:0]    len;
        logic [IW-1:0] id;
    } ar_t;

    logic          clk;
    logic          rst_n;
    logic          i_arvalid;
    logic          o_arready;
    logic [AW-1:0] i_araddr;
    logic [1:0]    i_arburst;
    logic [2:0]    i_arsize;
    logic [7:0]    i_arlen;
    logic [IW-1:0] i_arid;
    logic          o_rvalid;
    logic          i_rready;
    logic [DW-1:0] o_rdata;
    logic [1:0]    o_rresp;
    logic [IW-1:0] o_rid;
    logic          o_rlast;
    logic          o_dv;
    logic [AW-1:0] o_addr;
    logic [IW-1:0] o_id;
    logic [2:0]    o_size;
    logic          o_last;
    logic          i_hld;
    logic          i_err;
    logic [DW-1:0] i_rdata;

    // Scoreboard queues in AR order
    req_t          req_q[$];
    beat_t         beat_q[$];
    // Component latency line, index C_LAT drives the data
    logic          lat_v [C_LAT+1];
    logic [AW-1:0] lat_a [C_LAT+1];
    string         test_name;
    int            seed;
    int            mism_cnt;
    int            fail_cnt;
    int            cyc;
    int            lat_start;
    logic          lat_armed;
    logic          rand_mode;
    logic          rst_prev;

    axi_rd_sub i_axi_rd_sub (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Reference model
    // --------------------
    // Next beat address from the AXI burst rules
    function automatic logic [AW-1:0] next_addr(logic [AW-1:0] addr, logic [1:0] burst,
                                                logic [2:0] size, logic [7:0] len);
        int unsigned bytes;
        int unsigned algn;
        int unsigned region;
        int unsigned base;
        bytes  = 1 << size;
        algn   = addr - (addr % bytes);
        region = bytes * (len + 1);
        base   = addr - (addr % region);
        if (burst == AXI_BURST_INCR) begin
            return algn + bytes;
        end else if (burst == AXI_BURST_WRAP) begin
            // Offset rolls over inside the (len+1)-beat region
            return base + ((algn + bytes - base) % region);
        end
        return addr;
    endfunction

    function automatic void queue_burst(ar_t ar);
        logic [AW-1:0] a;
        logic [AW-1:0] word;
        a = ar.addr;
        for (int b = 0; b <= ar.len; b++) begin
            // Component only sees word addresses
            word = a - (a % (DW / 8));
            req_q.push_back('{addr: word, id: ar.id, size: ar.size, last: b == ar.len});
            beat_q.push_back('{data: word ^ DATA_KEY,
                               resp: (word >= ERR_LO && word < ERR_HI) ? AXI_RESP_SLVERR
                                                                      : AXI_RESP_OKAY,
                               id: ar.id, last: b == ar.len});
            a = next_addr(a, ar.burst, ar.size, ar.len);
        end
    endfunction

    task automatic check_val(string what, logic [63:0] exp_v, logic [63:0] act_v);
        assert (exp_v === act_v) else begin
            mism_cnt++;
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        end
    endtask

    // --------------------
    // Monitor
    // --------------------
    // Runs 1 ns after the falling edge and sees what the next rising edge takes
    task automatic sample_cycle();
        req_t  rq;
        beat_t bt;
        cyc++;
        if (!rst_n || !rst_prev) begin
            assert (!o_arready && !o_dv && !o_rvalid) else begin
                fail_cnt++;
                $display("Handshake output high in or right after reset, cycle %0d", cyc);
            end
        end
        rst_prev = rst_n;
        if (o_dv && !i_hld) begin
            assert (req_q.size() > 0) else begin
                fail_cnt++;
                $display("Component request with no burst outstanding in %s", test_name);
            end
            if (req_q.size() > 0) begin
                rq = req_q.pop_front();
                check_val("o_addr alignment", 0, o_addr % (DW / 8));
                check_val("o_addr", rq.addr, o_addr);
                check_val("o_id", rq.id, o_id);
                check_val("o_size", rq.size, o_size);
                check_val("o_last", rq.last, o_last);
            end
            lat_v[0] = 1'b1;
            lat_a[0] = o_addr;
        end
        if (o_rvalid && lat_armed) begin
            check_val("first rvalid delay", C_LAT + 1, cyc - lat_start);
            lat_armed = 1'b0;
        end
        if (o_rvalid && i_rready) begin
            assert (beat_q.size() > 0) else begin
                fail_cnt++;
                $display("R beat returned with no beat expected in %s", test_name);
            end
            if (beat_q.size() > 0) begin
                bt = beat_q.pop_front();
                check_val("o_rdata", bt.data, o_rdata);
                check_val("o_rresp", bt.resp, o_rresp);
                check_val("o_rid", bt.id, o_rid);
                check_val("o_rlast", bt.last, o_rlast);
            end
        end
        if (i_arvalid && o_arready) begin
            queue_burst('{addr: i_araddr, burst: i_arburst, size: i_arsize,
                          len: i_arlen, id: i_arid});
            if (test_name == "latency") begin
                lat_armed = 1'b1;
                lat_start = cyc;
            end
        end
    endtask

    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            #1;
            sample_cycle();
        end
    end

    // R payload holds while stalled
    assert property (@(posedge clk) disable iff (!rst_n)
        o_rvalid && !i_rready |=> o_rvalid && $stable({o_rdata, o_rresp, o_rid, o_rlast}))
    else begin
        fail_cnt++;
        $display("R channel changed while i_rready was low in %s", test_name);
    end

    // Component model, C_LAT cycles from request to data
    always @(negedge clk) begin
        for (int s = C_LAT; s > 0; s--) begin
            lat_v[s] = lat_v[s-1];
            lat_a[s] = lat_a[s-1];
        end
        lat_v[0] = 1'b0;
        i_rdata  = lat_v[C_LAT] ? (lat_a[C_LAT] ^ DATA_KEY) : '0;
        i_err    = lat_v[C_LAT] && lat_a[C_LAT] >= ERR_LO && lat_a[C_LAT] < ERR_HI;
    end

    // Back-pressure and hold, random only in the back-pressure test
    always @(negedge clk) begin
        if (rand_mode) begin
            i_rready = ($random(seed) & 3) != 0;
            i_hld    = ($random(seed) & 3) == 0;
        end else begin
            i_rready = 1'b1;
            i_hld    = 1'b0;
        end
    end

    initial begin
        #(WDOG_NS);
        $display("Timeout after %0d ns with %0d beats outstanding", WDOG_NS, beat_q.size());
        $display("Checks failed");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------
    // Caller sits on a falling edge, returns on the one after the handshake
    task automatic send_ar(ar_t ar);
        i_arvalid = 1'b1;
        i_araddr  = ar.addr;
        i_arburst = ar.burst;
        i_arsize  = ar.size;
        i_arlen   = ar.len;
        i_arid    = ar.id;
        #1;
        while (!o_arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        i_arvalid = 1'b0;
    endtask

    task automatic wait_idle();
        while (req_q.size() != 0 || beat_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    initial begin
        ar_t rnd [N_RAND];
        seed      = 32'h6daf;
        rst_n     = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arburst = '0;
        i_arsize  = '0;
        i_arlen   = '0;
        i_arid    = '0;
        i_rready  = 1'b1;
        i_hld     = 1'b0;
        i_err     = 1'b0;
        i_rdata   = '0;
        rand_mode = 1'b0;
        lat_armed = 1'b0;
        rst_prev  = 1'b0;
        mism_cnt  = 0;
        fail_cnt  = 0;
        cyc       = 0;
        test_name = "reset";
        for (int s = 0; s <= C_LAT; s++) begin
            lat_v[s] = 1'b0;
            lat_a[s] = '0;
        end
        // Random bursts around the error window, RESERVED included
        for (int k = 0; k < N_RAND; k++) begin
            rnd[k].burst = $random(seed) & 3;
            rnd[k].size  = {$random(seed)} % 3;
            rnd[k].id    = $random(seed) & 15;
            rnd[k].addr  = 32'h4f00 + ({$random(seed)} % 512);
            if (rnd[k].burst == AXI_BURST_WRAP) begin
                rnd[k].len  = (2 << ({$random(seed)} % 3)) - 1;
                rnd[k].addr = rnd[k].addr & ~((32'd1 << rnd[k].size) - 1);
            end else begin
                rnd[k].len  = {$random(seed)} % 8;
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "incr";
        send_ar('{addr: 32'h1000, burst: AXI_BURST_INCR, size: 3'd2, len: 8'd7, id: 4'h1});
        send_ar('{addr: 32'h2001, burst: AXI_BURST_INCR, size: 3'd0, len: 8'd9, id: 4'h2});
        send_ar('{addr: 32'h2102, burst: AXI_BURST_INCR, size: 3'd1, len: 8'd5, id: 4'h3});
        wait_idle();
        test_name = "fixed";
        send_ar('{addr: 32'h3006, burst: AXI_BURST_FIXED, size: 3'd1, len: 8'd3, id: 4'h4});
        wait_idle();
        test_name = "wrap";
        send_ar('{addr: 32'h4018, burst: AXI_BURST_WRAP, size: 3'd2, len: 8'd7, id: 4'h5});
        send_ar('{addr: 32'h4036, burst: AXI_BURST_WRAP, size: 3'd1, len: 8'd3, id: 4'h6});
        wait_idle();
        // Crosses into and out of the error window
        test_name = "error";
        send_ar('{addr: 32'h4ff8, burst: AXI_BURST_INCR, size: 3'd2, len: 8'd7, id: 4'h7});
        wait_idle();
        test_name = "latency";
        send_ar('{addr: 32'h6000, burst: AXI_BURST_INCR, size: 3'd2, len: 8'd3, id: 4'h8});
        wait_idle();

        test_name = "backpressure";
        @(posedge clk);
        rand_mode = 1'b1;
        @(negedge clk);
        for (int k = 0; k < N_RAND; k++) begin
            send_ar(rnd[k]);
        end
        wait_idle();

        $display("Error count: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt + fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
axi_rd_pkg.sv
rd_resp_if.sv
burst_addr_calc.sv
ar_txn_ctrl.sv
rd_ctx_pipe.sv
skid_buffer.sv
rd_data_pipe.sv
axi_rd_sub.sv
tb_axi_rd_sub.sv

/* Bender.yml */
package:
  name: axi_rd_sub

export_include_dirs:
  - .

sources:
  - files:
      - axi_rd_pkg.sv
      - rd_resp_if.sv
      - burst_addr_calc.sv
      - ar_txn_ctrl.sv
      - rd_ctx_pipe.sv
      - skid_buffer.sv
      - rd_data_pipe.sv
      - axi_rd_sub.sv
  - target: test
    files:
      - tb_axi_rd_sub.sv
